/* all.f */
hdl/core_cfg_pkg.sv
hdl/rv_isa_pkg.sv
hdl/core_fsm.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/lsu_align.sv
hdl/perf_counters.sv
hdl/rv_core_top.sv
verification/tb_bus_memory.sv
verification/tb_rv_core.sv

/* Makefile */
SIM = obj_dir/Vtb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_rv_core -Mdir obj_dir

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* verification/tb_rv_core.sv */
// Core testbench with clock, reset, program image, reference model, bus checks and watchdog
`default_nettype none
`timescale 1ns/10ps

module tb_rv_core;
	import core_cfg_pkg::*;
	import rv_isa_pkg::*;

	logic        clk_g;
	logic        rst_i;
	wire         ack;
	wire  [31:0] dat_rd;
	wire         cyc_o;
	wire         stb_o;
	wire         we_o;
	wire  [3:0]  sel_o;
	wire  [31:0] adr_o;
	wire  [31:0] dat_o;

	// Expected bus transfers in order with fetches included
	logic [31:0] q_adr [$];
	logic        q_we [$];
	logic [3:0]  q_sel [$];
	logic [31:0] q_dat [$];
	int          q_kind [$];	// 0 read, 1 exact write, 2 captured write
	logic [31:0] cap [$];
	logic [31:0] mreg [32];
	logic [31:0] dmem [int];
	logic [31:0] emit_pc;
	int          n_instr;
	int          data_off;
	bit          build_done;
	bit          done;
	bit          rst_seen;
	logic        prev_cyc;
	logic        prev_ack;
	logic        prev_we;
	logic [3:0]  prev_sel;
	logic [31:0] prev_adr;
	logic [31:0] prev_dat;

	rv_core_top DUT (
		.clk_g(clk_g), .rst_i(rst_i), .ack_i(ack), .dat_i(dat_rd),
		.cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o),
		.sel_o(sel_o), .adr_o(adr_o), .dat_o(dat_o)
	);

	tb_bus_memory u_mem (
		.clk_g(clk_g), .rst_i(rst_i), .cyc_i(cyc_o), .stb_i(stb_o), .we_i(we_o),
		.sel_i(sel_o), .adr_i(adr_o), .dat_i(dat_o), .ack_o(ack), .dat_o(dat_rd)
	);

	initial begin
		clk_g = 1'b0;
		forever #4 clk_g = ~clk_g;
	end

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic text_error(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		$display("Errors found");
		$fatal(1);
	endtask

	// ========================================
	// Reference model
	// ========================================
	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] ref_alu(input logic [2:0] f3, input bit alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
		F3_ADD:  return alt ? a - b : a + b;
		F3_SLL:  return a << b[4:0];
		F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
		F3_SLTU: return {31'b0, a < b};
		F3_XOR:  return a ^ b;
		F3_SR:   return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
		F3_OR:   return a | b;
		default: return a & b;
		endcase
	endfunction

	function automatic bit ref_branch(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
		F3_BEQ:  return a == b;
		F3_BNE:  return a != b;
		F3_BLT:  return $signed(a) < $signed(b);
		F3_BGE:  return $signed(a) >= $signed(b);
		F3_BLTU: return a < b;
		default: return a >= b;
		endcase
	endfunction

	function automatic logic [1:0] lane_of(input logic [2:0] f3, input logic [31:0] addr);
		if (f3 == F3_B || f3 == F3_BU)
			return addr[1:0];
		else if (f3 == F3_H || f3 == F3_HU)
			return {addr[1], 1'b0};
		return 2'b00;
	endfunction

	// Encoders
	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	// ========================================
	// Program emitters
	// ========================================
	task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
		if (rd != 0)
			mreg[rd] = v;
	endtask

	task automatic push_xfer(input logic [31:0] a, input logic w, input logic [3:0] s,
		input logic [31:0] d, input int kind);
		q_adr.push_back(a);
		q_we.push_back(w);
		q_sel.push_back(s);
		q_dat.push_back(d);
		q_kind.push_back(kind);
	endtask

	// Places a word; runs marks an instruction that the core fetches
	task automatic put(input logic [31:0] w, input bit runs);
		u_mem.mem[emit_pc[11:2]] = w;
		if (runs)
			push_xfer(emit_pc, 1'b0, 4'hf, '0, 0);
		emit_pc += 4;
		n_instr++;
	endtask

	task automatic li(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = (v + 32'h800) >> 12;
		put({hi[19:0], rd, OP_LUI}, 1);
		put(enc_i(v[11:0], rd, F3_ADD, rd, OP_ALUI), 1);
		set_reg(rd, v);
	endtask

	task automatic op_r(input logic [2:0] f3, input bit alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		put({alt ? F7_ALT : 7'b0, rs2, rs1, f3, rd, OP_ALU}, 1);
		set_reg(rd, ref_alu(f3, alt, mreg[rs1], mreg[rs2]));
	endtask

	task automatic op_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		put(enc_i(imm, rs1, f3, rd, OP_ALUI), 1);
		set_reg(rd, ref_alu(f3, f3 == F3_SR && imm[10], mreg[rs1], sext12(imm)));
	endtask

	task automatic store(input logic [2:0] f3, input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] off, input int kind);
		logic [31:0] addr;
		logic [1:0]  lane;
		logic [3:0]  sel;
		logic [31:0] d;
		int          wa;
		addr = mreg[rs1] + sext12(off);
		lane = lane_of(f3, addr);
		sel  = (f3 == F3_B) ? 4'b0001 << lane : (f3 == F3_H) ? 4'b0011 << lane : 4'hf;
		d    = mreg[rs2] << (8 * lane);
		wa   = int'(addr >> 2);
		put({off[11:5], rs2, rs1, f3, off[4:0], OP_STORE}, 1);
		push_xfer({addr[31:2], 2'b00}, 1'b1, sel, d, kind);
		if (!dmem.exists(wa))
			dmem[wa] = '0;
		for (int i = 0; i < 4; i++)
			if (sel[i])
				dmem[wa][8*i +: 8] = d[8*i +: 8];
	endtask

	task automatic store_w(input logic [4:0] rs);
		store(F3_W, rs, 20, data_off[11:0], 1);
		data_off += 4;
	endtask

	task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] off);
		logic [31:0] addr;
		logic [31:0] sh;
		addr = mreg[rs1] + sext12(off);
		sh   = dmem[int'(addr >> 2)] >> (8 * lane_of(f3, addr));
		put(enc_i(off, rs1, f3, rd, OP_LOAD), 1);
		push_xfer({addr[31:2], 2'b00}, 1'b0, 4'hf, '0, 0);
		case (f3)
		F3_B:    set_reg(rd, {{24{sh[7]}}, sh[7:0]});
		F3_BU:   set_reg(rd, {24'b0, sh[7:0]});
		F3_H:    set_reg(rd, {{16{sh[15]}}, sh[15:0]});
		F3_HU:   set_reg(rd, {16'b0, sh[15:0]});
		default: set_reg(rd, sh);
		endcase
	endtask

	// Forward branch over one addi on x9
	task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
		bit taken;
		taken = ref_branch(f3, mreg[rs1], mreg[rs2]);
		put(enc_b(13'd8, rs2, rs1, f3), 1);
		put(enc_i(12'd1, 9, F3_ADD, 9, OP_ALUI), !taken);
		if (!taken)
			set_reg(9, mreg[9] + 1);
	endtask

	task automatic jalr_skip(input logic [4:0] rd);
		logic [31:0] p;
		p = emit_pc;
		li(7, p + 17);	// Odd target so bit 0 gets cleared
		put(enc_i(12'd0, 7, 3'd0, rd, OP_JALR), 1);
		put(enc_i(12'd1, 9, F3_ADD, 9, OP_ALUI), 0);
		set_reg(rd, p + 12);
	endtask

	task automatic build_program();
		logic [2:0] br_f3 [6];
		int         known;	// Offset of the word that the loads read
		br_f3    = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
		emit_pc  = RESET_PC;
		n_instr  = 0;
		data_off = 0;
		mreg[0]  = '0;
		li(1, 32'h1234_5678);
		li(2, 32'hffff_f0f0);
		li(3, 32'd5);
		li(20, 32'h800);	// Data base
		li(9, 32'd0);
		put({20'h00010, 5'd4, OP_AUIPC}, 1);
		set_reg(4, emit_pc - 4 + 32'h0001_0000);
		store_w(1);
		store_w(4);
		for (int f = 0; f < 8; f++) begin
			op_r(3'(f), 1'b0, 5, 1, 2);
			store_w(5);
		end
		op_r(F3_ADD, 1'b1, 5, 1, 2);
		store_w(5);
		op_r(F3_SR, 1'b1, 5, 2, 3);
		store_w(5);
		op_i(F3_ADD, 5, 1, 12'hffb);
		store_w(5);
		op_i(F3_SLT, 5, 2, 12'h001);
		store_w(5);
		op_i(F3_SLTU, 5, 2, 12'h801);
		store_w(5);
		op_i(F3_XOR, 5, 1, 12'h5a5);
		store_w(5);
		op_i(F3_OR, 5, 2, 12'h00f);
		store_w(5);
		op_i(F3_AND, 5, 1, 12'h0ff);
		store_w(5);
		op_i(F3_SLL, 5, 1, 12'h007);
		store_w(5);
		op_i(F3_SR, 5, 2, 12'h004);
		store_w(5);
		op_i(F3_SR, 5, 2, 12'h404);	// srai
		store_w(5);

		// Branches, jumps and links
		li(6, 32'hffff_fffd);
		foreach (br_f3[b]) begin
			branch(br_f3[b], 3, 6);
			branch(br_f3[b], 3, 3);
		end
		store_w(9);
		set_reg(8, emit_pc + 4);
		put(enc_j(21'd8, 8), 1);
		put(enc_i(12'd1, 9, F3_ADD, 9, OP_ALUI), 0);
		store_w(8);
		jalr_skip(8);
		store_w(8);

		// Sub-word stores and loads
		li(22, 32'ha1b2_c3d4);
		for (int l = 0; l < 4; l++)
			store(F3_B, 22, 20, 12'(data_off + l), 1);
		data_off += 4;
		store(F3_H, 22, 20, 12'(data_off), 1);
		store(F3_H, 22, 20, 12'(data_off + 6), 1);
		data_off += 8;
		li(21, 32'h8091_a2b3);
		known = data_off;
		store(F3_W, 21, 20, 12'(known), 1);
		data_off += 4;
		for (int l = 0; l < 4; l++) begin
			load(F3_B, 5, 20, 12'(known + l));
			store_w(5);
			load(F3_BU, 5, 20, 12'(known + l));
			store_w(5);
		end
		for (int h = 0; h < 4; h += 2) begin
			load(F3_H, 5, 20, 12'(known + h));
			store_w(5);
			load(F3_HU, 5, 20, 12'(known + h));
			store_w(5);
		end

		// Counter reads with four instructions between each pair
		put(enc_i(CSR_INSTRET, 0, F3_CSRRS, 10, OP_SYSTEM), 1);
		put(enc_i(CSR_CYCLE, 0, F3_CSRRS, 11, OP_SYSTEM), 1);
		op_i(F3_ADD, 9, 9, 12'd1);
		op_i(F3_ADD, 9, 9, 12'd1);
		op_i(F3_ADD, 9, 9, 12'd1);
		put(enc_i(CSR_INSTRET, 0, F3_CSRRS, 12, OP_SYSTEM), 1);
		put(enc_i(CSR_CYCLE, 0, F3_CSRRS, 13, OP_SYSTEM), 1);
		for (int r = 10; r < 14; r++) begin
			store(F3_W, 5'(r), 20, 12'(data_off), 2);
			data_off += 4;
		end
		put(enc_j(21'd0, 0), 0);	// Parks the core
	endtask

	// ========================================
	// Bus checks
	// ========================================
	task automatic check_transfer();
		if (q_adr.size() == 0) begin
			text_error("bus transfer with none expected");
		end else begin
			assert (stb_o === 1'b1) else value_error("stb_o", stb_o, 1);
			assert (adr_o === q_adr[0]) else value_error("adr_o", adr_o, q_adr[0]);
			assert (we_o === q_we[0]) else value_error("we_o", we_o, q_we[0]);
			assert (sel_o === q_sel[0]) else value_error("sel_o", sel_o, q_sel[0]);
			if (q_kind[0] == 1)
				assert (dat_o === q_dat[0]) else value_error("dat_o", dat_o, q_dat[0]);
			else if (q_kind[0] == 2)
				cap.push_back(dat_o);
			void'(q_adr.pop_front());
			void'(q_we.pop_front());
			void'(q_sel.pop_front());
			void'(q_dat.pop_front());
			void'(q_kind.pop_front());
			if (q_adr.size() == 0)
				done = 1'b1;
		end
	endtask

	always @(posedge clk_g) begin
		if (rst_i) begin
			if (rst_seen)
				assert (cyc_o === 1'b0 && stb_o === 1'b0 && we_o === 1'b0)
				else text_error("bus strobes not low during reset");
			rst_seen <= 1'b1;
		end else if (build_done) begin
			if (prev_cyc && !prev_ack && cyc_o) begin	// Held until ack
				assert (adr_o === prev_adr) else value_error("adr_o", adr_o, prev_adr);
				assert (sel_o === prev_sel) else value_error("sel_o", sel_o, prev_sel);
				assert (we_o === prev_we) else value_error("we_o", we_o, prev_we);
				assert (dat_o === prev_dat) else value_error("dat_o", dat_o, prev_dat);
			end
			if (cyc_o && ack && !done)
				check_transfer();
		end
		prev_cyc <= cyc_o;
		prev_ack <= ack;
		prev_we  <= we_o;
		prev_sel <= sel_o;
		prev_adr <= adr_o;
		prev_dat <= dat_o;
	end

	// Watchdog allows 60 cycles per program word
	initial begin
		wait (build_done);
		repeat (n_instr * 60) @(posedge clk_g);
		$display("Watchdog expired before the program finished");
		$display("Errors found");
		$fatal(1);
	end

	initial begin
		rst_i      = 1'b1;
		build_done = 1'b0;
		done       = 1'b0;
		rst_seen   = 1'b0;
		@(posedge clk_g);
		build_program();
		build_done = 1'b1;
		repeat (7) @(posedge clk_g);
		@(negedge clk_g);
		rst_i = 1'b0;
		wait (done);
		assert (cap.size() == 4) else value_error("counter stores", cap.size(), 4);
		assert (cap[2] - cap[0] == 32'd5)
		else value_error("instret difference", cap[2] - cap[0], 5);
		assert (cap[3] - cap[1] >= 32'd20)
		else text_error("cycle counter advanced less than 4 cycles per instruction");
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/tb_bus_memory.sv */
// Word memory bus slave with random ack delays for the core testbench
`default_nettype none
`timescale 1ns/10ps

module tb_bus_memory (
	input  wire         clk_g,
	input  wire         rst_i,
	input  wire         cyc_i,
	input  wire         stb_i,
	input  wire         we_i,
	input  wire  [3:0]  sel_i,
	input  wire  [31:0] adr_i,
	input  wire  [31:0] dat_i,
	output logic        ack_o,
	output logic [31:0] dat_o
);
	logic [31:0] mem [0:1023];	// 4 KB of 32-bit words
	logic [31:0] rng;
	logic [1:0]  wait_cnt;
	logic        busy;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial begin
		ack_o = 1'b0;
		dat_o = '0;
		for (int i = 0; i < 1024; i++)
			mem[i] = 32'h5a5a_0000 ^ (i * 32'h9e37_79b9);	// Every address differs
	end

	// Responses change on the falling edge only
	always @(negedge clk_g) begin
		if (rst_i) begin
			ack_o    <= 1'b0;
			busy     <= 1'b0;
			wait_cnt <= '0;
			rng      <= 32'hf624;
		end else if (ack_o) begin
			ack_o <= 1'b0;	// Single cycle ack
		end else if (cyc_i && stb_i) begin
			if (!busy) begin
				busy     <= 1'b1;
				wait_cnt <= rng[1:0];
				rng      <= xorshift32(rng);
			end else if (wait_cnt != 0) begin
				wait_cnt <= wait_cnt - 1'b1;
			end else begin
				ack_o <= 1'b1;
				busy  <= 1'b0;
				if (we_i) begin
					for (int i = 0; i < 4; i++)
						if (sel_i[i])
							mem[adr_i[11:2]][8*i +: 8] <= dat_i[8*i +: 8];
				end else begin
					dat_o <= mem[adr_i[11:2]];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
// Top level of the multi-cycle RV32I core with its bus master port
`default_nettype none
`timescale 1ns/10ps

module rv_core_top (
	input  wire                               clk_g,
	input  wire                               rst_i,
	input  wire                               ack_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]     dat_i,
	output wire                               cyc_o,
	output wire                               stb_o,
	output wire                               we_o,
	output wire  [core_cfg_pkg::SEL_W-1:0]    sel_o,
	output wire  [core_cfg_pkg::XLEN-1:0]     adr_o,
	output wire  [core_cfg_pkg::XLEN-1:0]     dat_o
);
	import core_cfg_pkg::*;

	wire [6:0]        opcode;
	wire [2:0]        funct3;
	wire              alt;
	wire [REG_AW-1:0] rs1;
	wire [REG_AW-1:0] rs2;
	wire [REG_AW-1:0] rd;
	wire [XLEN-1:0]   imm;
	wire              is_load;
	wire              is_store;
	wire              is_branch;
	wire              is_jump;
	wire              is_csr;
	wire [11:0]       csr_addr;
	wire [XLEN-1:0]   rs1_val;
	wire [XLEN-1:0]   rs2_val;
	wire [XLEN-1:0]   alu_result;
	wire              take_branch;
	wire [XLEN-1:0]   target;
	wire [XLEN-1:0]   link;
	wire [SEL_W-1:0]  mem_sel;
	wire [XLEN-1:0]   store_data;
	wire [XLEN-1:0]   load_data;
	wire [XLEN-1:0]   csr_data;
	wire [XLEN-1:0]   pc;
	wire              ir_load;
	wire              rf_we;
	wire [XLEN-1:0]   rf_wdata;
	wire              retire;

	core_fsm u_fsm (
		.clk_g(clk_g), .rst_i(rst_i), .ack_i(ack_i),
		.is_load_i(is_load), .is_store_i(is_store), .is_branch_i(is_branch),
		.is_jump_i(is_jump), .is_csr_i(is_csr), .rd_i(rd),
		.alu_result_i(alu_result), .take_branch_i(take_branch),
		.target_i(target), .link_i(link),
		.mem_sel_i(mem_sel), .store_data_i(store_data),
		.load_data_i(load_data), .csr_data_i(csr_data),
		.pc_o(pc), .ir_load_o(ir_load), .rf_we_o(rf_we),
		.rf_wdata_o(rf_wdata), .retire_o(retire),
		.cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o),
		.sel_o(sel_o), .adr_o(adr_o), .dat_o(dat_o)
	);

	instr_decode u_decode (
		.clk_g(clk_g), .rst_i(rst_i), .ir_load_i(ir_load), .dat_i(dat_i),
		.opcode_o(opcode), .funct3_o(funct3), .alt_o(alt),
		.rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
		.is_load_o(is_load), .is_store_o(is_store), .is_branch_o(is_branch),
		.is_jump_o(is_jump), .is_csr_o(is_csr), .csr_addr_o(csr_addr)
	);

	reg_file u_regs (
		.clk_g(clk_g), .we_i(rf_we), .waddr_i(rd), .wdata_i(rf_wdata),
		.raddr_a_i(rs1), .raddr_b_i(rs2),
		.rdata_a_o(rs1_val), .rdata_b_o(rs2_val)
	);

	alu u_alu (
		.opcode_i(opcode), .funct3_i(funct3), .alt_i(alt), .pc_i(pc),
		.rs1_val_i(rs1_val), .rs2_val_i(rs2_val), .imm_i(imm),
		.result_o(alu_result), .take_branch_o(take_branch),
		.target_o(target), .link_o(link)
	);

	lsu_align u_lsu (
		.funct3_i(funct3), .is_store_i(is_store), .addr_lo_i(alu_result[1:0]),
		.rs2_val_i(rs2_val), .dat_i(dat_i),
		.mem_sel_o(mem_sel), .store_data_o(store_data), .load_data_o(load_data)
	);

	perf_counters u_perf (
		.clk_g(clk_g), .rst_i(rst_i), .retire_i(retire),
		.csr_addr_i(csr_addr), .csr_data_o(csr_data)
	);

endmodule

`default_nettype wire

/* hdl/perf_counters.sv */
// Cycle and retired instruction counters with their CSR read mux
`default_nettype none
`timescale 1ns/10ps

module perf_counters (
	input  wire                               clk_g,
	input  wire                               rst_i,
	input  wire                               retire_i,
	input  wire  [11:0]                       csr_addr_i,
	output logic [core_cfg_pkg::XLEN-1:0]     csr_data_o
);
	import core_cfg_pkg::*;

	logic [XLEN-1:0] cycle_cnt;
	logic [XLEN-1:0] instret_cnt;

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			cycle_cnt   <= '0;
			instret_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1;	// Every clock
			if (retire_i)
				instret_cnt <= instret_cnt + 1'b1;
		end
	end

	always_comb begin
		case (csr_addr_i)
		CSR_CYCLE:   csr_data_o = cycle_cnt;
		CSR_INSTRET: csr_data_o = instret_cnt;
		default:     csr_data_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/lsu_align.sv */
// Byte lane selects, store data placement and load extraction
`default_nettype none
`timescale 1ns/10ps

module lsu_align (
	input  wire  [2:0]                        funct3_i,
	input  wire                               is_store_i,
	input  wire  [1:0]                        addr_lo_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]     rs2_val_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]     dat_i,
	output logic [core_cfg_pkg::SEL_W-1:0]    mem_sel_o,
	output logic [core_cfg_pkg::XLEN-1:0]     store_data_o,
	output logic [core_cfg_pkg::XLEN-1:0]     load_data_o
);
	import core_cfg_pkg::*;
	import rv_isa_pkg::*;

	logic [1:0]       lane;
	logic [SEL_W-1:0] size_mask;
	logic [XLEN-1:0]  shifted;	// Addressed lane moved to bit 0

	// Offset bits below the access size are dropped
	always_comb begin
		case (funct3_i)
		F3_B, F3_BU: begin
			lane      = addr_lo_i;
			size_mask = 4'b0001;
		end
		F3_H, F3_HU: begin
			lane      = {addr_lo_i[1], 1'b0};
			size_mask = 4'b0011;
		end
		default: begin
			lane      = 2'b00;
			size_mask = 4'b1111;
		end
		endcase
	end

	assign mem_sel_o    = is_store_i ? size_mask << lane : '1;	// Loads read the whole word
	assign store_data_o = rs2_val_i << {lane, 3'b000};
	assign shifted      = dat_i >> {lane, 3'b000};

	always_comb begin
		case (funct3_i)
		F3_B:    load_data_o = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
		F3_BU:   load_data_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
		F3_H:    load_data_o = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
		F3_HU:   load_data_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
		default: load_data_o = shifted;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/alu.sv */
// Integer ALU, branch compare, jump target and link value
`default_nettype none
`timescale 1ns/10ps

module alu (
	input  wire  [6:0]                        opcode_i,
	input  wire  [2:0]                        funct3_i,
	input  wire                               alt_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]     pc_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]     rs1_val_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]     rs2_val_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]     imm_i,
	output logic [core_cfg_pkg::XLEN-1:0]     result_o,
	output logic                              take_branch_o,
	output logic [core_cfg_pkg::XLEN-1:0]     target_o,
	output logic [core_cfg_pkg::XLEN-1:0]     link_o
);
	import core_cfg_pkg::*;
	import rv_isa_pkg::*;

	logic [XLEN-1:0] op_b;
	logic [4:0]      shamt;
	logic [XLEN-1:0] addr_sum;	// rs1 + imm
	logic [XLEN-1:0] sra_val;
	logic [XLEN-1:0] alu_val;

	assign op_b     = (opcode_i == OP_ALU) ? rs2_val_i : imm_i;
	assign shamt    = op_b[4:0];
	assign addr_sum = rs1_val_i + imm_i;
	assign sra_val  = $signed(rs1_val_i) >>> shamt;

	always_comb begin
		case (funct3_i)
		F3_ADD:  alu_val = (opcode_i == OP_ALU && alt_i) ? rs1_val_i - op_b :
			rs1_val_i + op_b;
		F3_SLL:  alu_val = rs1_val_i << shamt;
		F3_SLT:  alu_val = XLEN'($signed(rs1_val_i) < $signed(op_b));
		F3_SLTU: alu_val = XLEN'(rs1_val_i < op_b);
		F3_XOR:  alu_val = rs1_val_i ^ op_b;
		F3_SR:   alu_val = alt_i ? sra_val : rs1_val_i >> shamt;
		F3_OR:   alu_val = rs1_val_i | op_b;
		default: alu_val = rs1_val_i & op_b;
		endcase
	end

	always_comb begin
		case (opcode_i)
		OP_LUI:          result_o = imm_i;
		OP_AUIPC:        result_o = pc_i + imm_i;
		OP_ALU, OP_ALUI: result_o = alu_val;
		default:         result_o = addr_sum;	// Load and store address
		endcase
	end

	// Compare only; the sequencer qualifies with the branch class
	always_comb begin
		case (funct3_i)
		F3_BEQ:  take_branch_o = rs1_val_i == rs2_val_i;
		F3_BNE:  take_branch_o = rs1_val_i != rs2_val_i;
		F3_BLT:  take_branch_o = $signed(rs1_val_i) < $signed(rs2_val_i);
		F3_BGE:  take_branch_o = $signed(rs1_val_i) >= $signed(rs2_val_i);
		F3_BLTU: take_branch_o = rs1_val_i < rs2_val_i;
		F3_BGEU: take_branch_o = rs1_val_i >= rs2_val_i;
		default: take_branch_o = 1'b0;
		endcase
	end

	assign target_o = (opcode_i == OP_JALR) ? {addr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;
	assign link_o   = pc_i + XLEN'(4);

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
// Integer register file, x0 hard wired to zero
`default_nettype none
`timescale 1ns/10ps

module reg_file (
	input  wire                               clk_g,
	input  wire                               we_i,
	input  wire  [core_cfg_pkg::REG_AW-1:0]   waddr_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]     wdata_i,
	input  wire  [core_cfg_pkg::REG_AW-1:0]   raddr_a_i,
	input  wire  [core_cfg_pkg::REG_AW-1:0]   raddr_b_i,
	output logic [core_cfg_pkg::XLEN-1:0]     rdata_a_o,
	output logic [core_cfg_pkg::XLEN-1:0]     rdata_b_o
);
	import core_cfg_pkg::*;

	logic [XLEN-1:0] regs [1:31];	// No storage for x0

	always_ff @(posedge clk_g) begin
		if (we_i && waddr_i != '0)
			regs[waddr_i] <= wdata_i;
	end

	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

/* hdl/instr_decode.sv */
// Instruction register, field extraction, immediates and opcode class
`default_nettype none
`timescale 1ns/10ps

module instr_decode (
	input  wire                               clk_g,
	input  wire                               rst_i,
	input  wire                               ir_load_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]     dat_i,
	output logic [6:0]                        opcode_o,
	output logic [2:0]                        funct3_o,
	output logic                              alt_o,
	output logic [core_cfg_pkg::REG_AW-1:0]   rs1_o,
	output logic [core_cfg_pkg::REG_AW-1:0]   rs2_o,
	output logic [core_cfg_pkg::REG_AW-1:0]   rd_o,
	output logic [core_cfg_pkg::XLEN-1:0]     imm_o,
	output logic                              is_load_o,
	output logic                              is_store_o,
	output logic                              is_branch_o,
	output logic                              is_jump_o,
	output logic                              is_csr_o,
	output logic [11:0]                       csr_addr_o
);
	import rv_isa_pkg::*;

	instr_u ir;
	logic   sgn;
	logic   writes_rd;

	always_ff @(posedge clk_g) begin
		if (rst_i)
			ir <= 32'h0000_0013;	// addi x0, x0, 0
		else if (ir_load_i)
			ir <= dat_i;
	end

	assign opcode_o   = ir.r.opcode;
	assign funct3_o   = ir.r.funct3;
	assign alt_o      = ir.r.funct7 == F7_ALT;
	assign rs1_o      = ir.r.rs1;
	assign rs2_o      = ir.r.rs2;
	assign csr_addr_o = ir.i.imm12;
	assign sgn        = ir.i.imm12[11];

	// Immediate by format
	always_comb begin
		case (opcode_o)
		OP_LUI, OP_AUIPC:
			imm_o = {ir.i.imm12, ir.i.rs1, ir.i.funct3, 12'h000};
		OP_JAL:
			imm_o = {{12{sgn}}, ir.i.rs1, ir.i.funct3, ir.i.imm12[0],
				ir.i.imm12[10:1], 1'b0};
		OP_BRANCH:
			imm_o = {{20{sgn}}, ir.s.imm_lo[0], ir.s.imm_hi[5:0],
				ir.s.imm_lo[4:1], 1'b0};
		OP_STORE:
			imm_o = {{20{sgn}}, ir.s.imm_hi, ir.s.imm_lo};
		default:
			imm_o = {{20{sgn}}, ir.i.imm12};
		endcase
	end

	assign is_load_o   = opcode_o == OP_LOAD;
	assign is_store_o  = opcode_o == OP_STORE;
	assign is_branch_o = opcode_o == OP_BRANCH;
	assign is_jump_o   = (opcode_o == OP_JAL) || (opcode_o == OP_JALR);
	assign is_csr_o    = (opcode_o == OP_SYSTEM) && (funct3_o == F3_CSRRS);

	// Unknown opcodes fall out here and retire as no-ops
	assign writes_rd = is_csr_o ||
		(opcode_o inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_ALUI, OP_ALU});
	assign rd_o = writes_rd ? ir.i.rd : '0;

endmodule

`default_nettype wire

/* hdl/core_fsm.sv */
// Control sequencer with PC, bus master control and writeback select
`default_nettype none
`timescale 1ns/10ps

module core_fsm (
	input  wire                                 clk_g,
	input  wire                                 rst_i,
	input  wire                                 ack_i,
	input  wire                                 is_load_i,
	input  wire                                 is_store_i,
	input  wire                                 is_branch_i,
	input  wire                                 is_jump_i,
	input  wire                                 is_csr_i,
	input  wire  [core_cfg_pkg::REG_AW-1:0]     rd_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]       alu_result_i,
	input  wire                                 take_branch_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]       target_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]       link_i,
	input  wire  [core_cfg_pkg::SEL_W-1:0]      mem_sel_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]       store_data_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]       load_data_i,
	input  wire  [core_cfg_pkg::XLEN-1:0]       csr_data_i,
	output logic [core_cfg_pkg::XLEN-1:0]       pc_o,
	output logic                                ir_load_o,
	output logic                                rf_we_o,
	output logic [core_cfg_pkg::XLEN-1:0]       rf_wdata_o,
	output logic                                retire_o,
	output logic                                cyc_o,
	output logic                                stb_o,
	output logic                                we_o,
	output logic [core_cfg_pkg::SEL_W-1:0]      sel_o,
	output logic [core_cfg_pkg::XLEN-1:0]       adr_o,
	output logic [core_cfg_pkg::XLEN-1:0]       dat_o
);
	import core_cfg_pkg::*;

	logic [2:0]      state;
	logic            is_mem;
	logic            exec_done;	// Non-memory instruction finishes
	logic            mem_done;
	logic [XLEN-1:0] next_pc;

	assign is_mem    = is_load_i | is_store_i;
	assign exec_done = (state == ST_EXECUTE) && !is_mem;
	assign mem_done  = (state == ST_MEM_WAIT) && ack_i;
	assign ir_load_o = (state == ST_FETCH_WAIT) && ack_i;
	assign retire_o  = exec_done | mem_done;
	assign rf_we_o   = (rd_i != '0) && (exec_done || (mem_done && is_load_i));

	assign rf_wdata_o = is_jump_i ? link_i :
		is_csr_i  ? csr_data_i :
		is_load_i ? load_data_i : alu_result_i;

	assign next_pc = (is_jump_i || (is_branch_i && take_branch_i)) ? target_i :
		pc_o + XLEN'(4);

	// ========================================
	// State, PC and bus strobes
	// ========================================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			state <= ST_FETCH;
			pc_o  <= RESET_PC;
			cyc_o <= 1'b0;
			stb_o <= 1'b0;
			we_o  <= 1'b0;
		end else begin
			case (state)
			ST_FETCH: begin
				cyc_o <= 1'b1;
				stb_o <= 1'b1;
				we_o  <= 1'b0;
				state <= ST_FETCH_WAIT;
			end
			ST_FETCH_WAIT: begin
				if (ack_i) begin
					cyc_o <= 1'b0;	// Drop the cycle after ack
					stb_o <= 1'b0;
					state <= ST_DECODE;
				end
			end
			ST_DECODE: state <= ST_EXECUTE;	// Register reads settle
			ST_EXECUTE: begin
				if (is_mem) begin
					cyc_o <= 1'b1;
					stb_o <= 1'b1;
					we_o  <= is_store_i;
					state <= ST_MEM_WAIT;
				end else begin
					pc_o  <= next_pc;
					state <= ST_FETCH;
				end
			end
			ST_MEM_WAIT: begin
				if (ack_i) begin
					cyc_o <= 1'b0;
					stb_o <= 1'b0;
					we_o  <= 1'b0;
					pc_o  <= next_pc;
					state <= ST_FETCH;
				end
			end
			default: state <= ST_FETCH;
			endcase
		end
	end

	// Address, lanes and write data held until the cycle ends
	always_ff @(posedge clk_g) begin
		if (state == ST_FETCH) begin
			sel_o <= '1;
			adr_o <= pc_o;
		end else if (state == ST_EXECUTE && is_mem) begin
			sel_o <= mem_sel_i;
			adr_o <= {alu_result_i[XLEN-1:2], 2'b00};	// Word aligned
			dat_o <= store_data_i;
		end
	end

endmodule

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
// RV32I opcodes, funct codes and the instruction word union
`default_nettype none

package rv_isa_pkg;

	// ========================================
	// Major opcodes
	// ========================================
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_ALUI   = 7'b0010011;
	localparam logic [6:0] OP_ALU    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// ALU funct3
	localparam logic [2:0] F3_ADD  = 3'd0;	// Also sub
	localparam logic [2:0] F3_SLL  = 3'd1;
	localparam logic [2:0] F3_SLT  = 3'd2;
	localparam logic [2:0] F3_SLTU = 3'd3;
	localparam logic [2:0] F3_XOR  = 3'd4;
	localparam logic [2:0] F3_SR   = 3'd5;	// srl and sra
	localparam logic [2:0] F3_OR   = 3'd6;
	localparam logic [2:0] F3_AND  = 3'd7;

	// Load and store sizes
	localparam logic [2:0] F3_B  = 3'd0;
	localparam logic [2:0] F3_H  = 3'd1;
	localparam logic [2:0] F3_W  = 3'd2;
	localparam logic [2:0] F3_BU = 3'd4;
	localparam logic [2:0] F3_HU = 3'd5;

	// Branch conditions
	localparam logic [2:0] F3_BEQ  = 3'd0;
	localparam logic [2:0] F3_BNE  = 3'd1;
	localparam logic [2:0] F3_BLT  = 3'd4;
	localparam logic [2:0] F3_BGE  = 3'd5;
	localparam logic [2:0] F3_BLTU = 3'd6;
	localparam logic [2:0] F3_BGEU = 3'd7;

	localparam logic [2:0] F3_CSRRS = 3'd2;
	localparam logic [6:0] F7_ALT   = 7'b0100000;	// sub, sra

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
	} instr_u;

endpackage

`default_nettype wire

/* hdl/core_cfg_pkg.sv */
// Core widths, reset PC, control state codes and counter CSR addresses
`default_nettype none

package core_cfg_pkg;

	localparam int XLEN   = 32;	// Data and address width
	localparam int SEL_W  = 4;	// One select per byte lane
	localparam int REG_AW = 5;

	localparam logic [31:0] RESET_PC = 32'h0000_0100;

	// Control sequence
	localparam logic [2:0] ST_FETCH      = 3'd0;
	localparam logic [2:0] ST_FETCH_WAIT = 3'd1;
	localparam logic [2:0] ST_DECODE     = 3'd2;
	localparam logic [2:0] ST_EXECUTE    = 3'd3;
	localparam logic [2:0] ST_MEM_WAIT   = 3'd4;

	localparam logic [11:0] CSR_CYCLE   = 12'hC00;
	localparam logic [11:0] CSR_INSTRET = 12'hC02;

endpackage

`default_nettype wire
